/* logic/iserdes_lane.sv */
`timescale 1ns/1ps
`include "serdes_defines.svh"

module iserdes_lane
	import serdes_pkg::*;
(
	input  logic clock,
	input  logic rst_n,
	input  logic bit_in, // delayed rx bit
	output rx_word_t word, // last four bits, oldest in the msb
	output logic valid // one cycle per completed word
);
	localparam int PHASE_BITS = $clog2(`SERDES_RX_BITS);
	localparam logic [PHASE_BITS-1:0] LAST_PHASE = PHASE_BITS'(`SERDES_RX_BITS - 1);

	logic [PHASE_BITS-1:0] phase; // bits taken into the current word

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			phase <= '0;
			word <= '0;
			valid <= 1'b0;
		end else begin
			phase <= phase + 1'b1; // free running, wraps every word
			word <= {word[`SERDES_RX_BITS-2:0], bit_in}; // shift in at the lsb
			valid <= (phase == LAST_PHASE); // word complete after this bit
		end
	end

endmodule

/* logic/oserdes_lane.sv */
`timescale 1ns/1ps
`include "serdes_defines.svh"

module oserdes_lane
	import serdes_pkg::*;
(
	input  logic clock,
	input  logic rst_n,
	input  logic load, // take word at this edge
	input  tx_word_t word,
	output logic bit_out // msb first, 0 when idle
);
	localparam int REMAIN_BITS = $clog2(`SERDES_WORD_BITS + 1);

	tx_word_t shift_reg; // next bit to send sits in the msb
	logic [REMAIN_BITS-1:0] remain; // bits still to send

	always_ff @(posedge clock) begin
		if (load) begin
			shift_reg <= word;
		end else begin
			shift_reg <= shift_reg << 1; // move the next bit up
		end
	end

	// a new strobe restarts the word even if the old one is not done
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			remain <= '0;
		end else if (load) begin
			remain <= REMAIN_BITS'(`SERDES_WORD_BITS);
		end else if (remain != '0) begin
			remain <= remain - 1'b1;
		end
	end

	assign bit_out = (remain != '0) && shift_reg[`SERDES_WORD_BITS-1]; // idle line is low

endmodule

/* logic/rx_delay_line.sv */
`timescale 1ns/1ps
`include "serdes_defines.svh"

module rx_delay_line
	import serdes_pkg::*;
(
	input  logic clock,
	input  logic rst_n,
	input  logic bit_in, // raw received bit
	input  delay_ctrl_t ctrl,
	output tap_t tap, // current delay setting
	output logic bit_out // bit_in from tap+1 cycles ago
);
	localparam int DEPTH = 2 ** `SERDES_TAP_BITS;

	logic [DEPTH-1:0] history; // entry k was sampled k+1 cycles ago

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			history <= '0;
		end else begin
			history <= {history[DEPTH-2:0], bit_in}; // newest sample in entry 0
		end
	end

	// tap counter wraps both ways like the variable iodelay
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tap <= '0;
		end else if (ctrl.strobe) begin
			if (ctrl.inc_not_dec) begin
				tap <= tap + 1'b1; // 15 wraps to 0
			end else begin
				tap <= tap - 1'b1; // 0 wraps to 15
			end
		end
	end

	assign bit_out = history[tap]; // new tap takes effect the cycle after the strobe

endmodule

/* logic/serdes_defines.svh */
`ifndef SERDES_DEFINES_SVH
`define SERDES_DEFINES_SVH

// bits per tx word, also bit clocks per word period
`define SERDES_WORD_BITS 8

// lane groups, each on its own word-load strobe
`define SERDES_GROUP0_LANES 4
`define SERDES_GROUP1_LANES 2
`define SERDES_TX_LANES (`SERDES_GROUP0_LANES + `SERDES_GROUP1_LANES)

// group 1 strobe phase, in bit periods after group 0
`define SERDES_PHASE_SEL_BITS 2

// word periods from reset release until lock
`define SERDES_LOCK_WORDS 4

// rx delay taps (16) and deserializer word width
`define SERDES_TAP_BITS 4
`define SERDES_RX_BITS 4

`endif

/* logic/serdes_pkg.sv */
`include "serdes_defines.svh"

package serdes_pkg;

	typedef logic [`SERDES_WORD_BITS-1:0] tx_word_t; // one lane, sent msb first

	// parallel words for all six tx lanes
	typedef struct packed {
		tx_word_t lane0; // group 0
		tx_word_t lane1;
		tx_word_t lane2;
		tx_word_t lane3;
		tx_word_t lane4; // group 1
		tx_word_t lane5;
	} tx_bank_t;

	// rx delay adjust request
	typedef struct packed {
		logic strobe; // one cycle, moves the tap by one
		logic inc_not_dec; // 1 adds a tap, 0 removes one
	} delay_ctrl_t;

	typedef logic [`SERDES_RX_BITS-1:0] rx_word_t; // oldest bit in the msb
	typedef logic [`SERDES_TAP_BITS-1:0] tap_t; // wraps modulo 16

endpackage

/* logic/serdes_top.sv */
`timescale 1ns/1ps
`include "serdes_defines.svh"

module serdes_top
	import serdes_pkg::*;
(
	input  logic clock, // bit clock
	input  logic rst_n,
	input  tx_bank_t tx_words, // parallel words for the six lanes
	input  logic [`SERDES_PHASE_SEL_BITS-1:0] word_clock1_sel, // group 1 phase
	input  logic rx_bit,
	input  delay_ctrl_t delay_ctrl,
	output logic [`SERDES_TX_LANES-1:0] tx_bits, // bit i is lane i
	output logic load0, // lanes 0-3 take their words
	output logic load1, // lanes 4-5 take their words
	output logic locked,
	output tap_t tap,
	output rx_word_t rx_word,
	output logic rx_valid
);
	tx_word_t [`SERDES_TX_LANES-1:0] lane_words; // indexed by lane number
	logic rx_delayed; // rx bit after the tap delay

	assign lane_words = {tx_words.lane5, tx_words.lane4, tx_words.lane3,
		tx_words.lane2, tx_words.lane1, tx_words.lane0};

	strobe_gen u_strobe_gen (
		.clock     (clock),
		.rst_n     (rst_n),
		.phase_sel (word_clock1_sel),
		.load0     (load0),
		.load1     (load1),
		.locked    (locked)
	);

	// hex lanes split 4/2 across the two word strobes
	for (genvar i = 0; i < `SERDES_TX_LANES; i++) begin : g_tx_lane
		oserdes_lane u_lane (
			.clock   (clock),
			.rst_n   (rst_n),
			.load    ((i < `SERDES_GROUP0_LANES) ? load0 : load1),
			.word    (lane_words[i]),
			.bit_out (tx_bits[i])
		);
	end

	rx_delay_line u_rx_delay (
		.clock   (clock),
		.rst_n   (rst_n),
		.bit_in  (rx_bit),
		.ctrl    (delay_ctrl),
		.tap     (tap),
		.bit_out (rx_delayed)
	);

	iserdes_lane u_iserdes (
		.clock  (clock),
		.rst_n  (rst_n),
		.bit_in (rx_delayed),
		.word   (rx_word),
		.valid  (rx_valid)
	);

endmodule

/* logic/strobe_gen.sv */
`timescale 1ns/1ps
`include "serdes_defines.svh"

module strobe_gen (
	input  logic clock, // bit clock
	input  logic rst_n,
	input  logic [`SERDES_PHASE_SEL_BITS-1:0] phase_sel, // requested group 1 phase
	output logic load0, // group 0 word strobe
	output logic load1, // group 1 word strobe, phase shifted
	output logic locked
);
	localparam int CNT_BITS = $clog2(`SERDES_WORD_BITS);
	localparam int LOCK_BITS = $clog2(`SERDES_LOCK_WORDS);
	localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`SERDES_WORD_BITS - 1);
	localparam logic [LOCK_BITS-1:0] LAST_WORD = LOCK_BITS'(`SERDES_LOCK_WORDS - 1);

	logic [CNT_BITS-1:0] bit_cnt; // bit position inside the word period
	logic [LOCK_BITS-1:0] lock_cnt; // word periods finished before lock
	logic [`SERDES_PHASE_SEL_BITS-1:0] phase; // active group 1 phase
	logic word_end; // last bit of the current word period

	assign word_end = (bit_cnt == LAST_BIT);

	// word period divider, stands in for the pll divided clock
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (word_end) begin
			bit_cnt <= '0; // next word period
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// lock after a fixed number of word periods, held until reset
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			lock_cnt <= '0;
			locked <= 1'b0;
		end else if (word_end && !locked) begin
			lock_cnt <= lock_cnt + 1'b1;
			if (lock_cnt == LAST_WORD) begin
				locked <= 1'b1; // last lock period ends here
			end
		end
	end

	// phase only changes at a word boundary so group 1 never sees a torn period
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (word_end) begin
			phase <= phase_sel; // sampled even before lock
		end
	end

	assign load0 = locked && word_end; // one pulse per word period
	assign load1 = locked && (bit_cnt == CNT_BITS'(phase)); // phase+1 bits after load0

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the serdes testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_serdes_top \
	-o tb_serdes_top > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status, see $BUILD_LOG"
	exit 1
fi

./obj_dir/tb_serdes_top > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status, see $SIM_LOG"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$SIM_LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $SIM_LOG"
	exit 1
fi

/* sim.f */
+incdir+logic
logic/serdes_pkg.sv
logic/strobe_gen.sv
logic/oserdes_lane.sv
logic/rx_delay_line.sv
logic/iserdes_lane.sv
logic/serdes_top.sv
verification/tb_serdes_top.sv

/* verification/tb_serdes_top.sv */
`timescale 1ns/1ps
`include "serdes_defines.svh"

module tb_serdes_top
	import serdes_pkg::*;
();
	localparam logic [31:0] SEED = 32'h61c990f3;
	localparam int RESET_CYCLES = 3;
	localparam int TEST_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES; // twice the test length
	localparam int WORD = `SERDES_WORD_BITS;
	localparam int LOCK_CYCLE = `SERDES_LOCK_WORDS * `SERDES_WORD_BITS; // 32 bit clocks
	localparam int HIST_DEPTH = 2 ** `SERDES_TAP_BITS;

	logic clock = 1'b0;
	logic rst_n;
	tx_bank_t tx_words;
	logic [`SERDES_PHASE_SEL_BITS-1:0] word_clock1_sel;
	logic rx_bit;
	delay_ctrl_t delay_ctrl;
	logic [`SERDES_TX_LANES-1:0] tx_bits;
	logic load0;
	logic load1;
	logic locked;
	tap_t tap;
	rx_word_t rx_word;
	logic rx_valid;

	// reference model state right after each edge
	int since_release; // edges seen with reset released
	logic [`SERDES_PHASE_SEL_BITS-1:0] m_phase; // phase latched at the last word end
	tx_word_t m_word [0:`SERDES_TX_LANES-1]; // word captured per lane
	logic [3:0] m_left [0:`SERDES_TX_LANES-1]; // bits of that word still to show
	logic [HIST_DEPTH-1:0] m_hist; // bit 0 is the newest rx sample
	tap_t m_tap;
	rx_word_t m_rx_word;
	int wraps_up = 0; // tap wrapped from 15 to 0
	int wraps_down = 0; // tap wrapped from 0 to 15
	int cycle_count = 0;

	serdes_top u_serdes_top (
		.clock           (clock),
		.rst_n           (rst_n),
		.tx_words        (tx_words),
		.word_clock1_sel (word_clock1_sel),
		.rx_bit          (rx_bit),
		.delay_ctrl      (delay_ctrl),
		.tx_bits         (tx_bits),
		.load0           (load0),
		.load1           (load1),
		.locked          (locked),
		.tap             (tap),
		.rx_word         (rx_word),
		.rx_valid        (rx_valid)
	);

	always #2 clock = ~clock; // 4 ns bit clock

	// hard stop in case the main loop stalls
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("CHECKS FAILED");
			$fatal(1, "timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	function automatic logic exp_locked();
		return since_release >= LOCK_CYCLE; // end of the 4th word period
	endfunction

	function automatic logic exp_load0();
		return exp_locked() && (since_release % WORD == WORD - 1);
	endfunction

	function automatic logic exp_load1();
		return exp_locked() && (since_release % WORD == int'(m_phase)); // phase+1 bits late
	endfunction

	task automatic reset_model();
		since_release = 0;
		m_phase = '0;
		m_hist = '0;
		m_tap = '0;
		m_rx_word = '0;
		for (int i = 0; i < `SERDES_TX_LANES; i++) begin
			m_word[i] = '0;
			m_left[i] = '0;
		end
	endtask

	// advance the model by one edge using the inputs held across it
	task automatic step_model();
		logic ld0;
		logic ld1;
		logic delayed;
		if (!rst_n) begin
			reset_model();
		end else begin
			ld0 = exp_load0(); // strobes as seen just before the edge
			ld1 = exp_load1();
			delayed = m_hist[m_tap];
			for (int i = 0; i < `SERDES_TX_LANES; i++) begin
				if ((i < `SERDES_GROUP0_LANES) ? ld0 : ld1) begin
					m_word[i] = tx_words[WORD*(`SERDES_TX_LANES-1-i) +: WORD]; // lane0 on top
					m_left[i] = 4'(WORD);
				end else if (m_left[i] != 4'd0) begin
					m_left[i] = m_left[i] - 4'd1;
				end
			end
			if (since_release % WORD == WORD - 1) begin
				m_phase = word_clock1_sel; // latched at every word end even before lock
			end
			if (delay_ctrl.strobe) begin
				if (delay_ctrl.inc_not_dec) begin
					wraps_up += int'(m_tap == 4'd15);
					m_tap = m_tap + 4'd1;
				end else begin
					wraps_down += int'(m_tap == 4'd0);
					m_tap = m_tap - 4'd1;
				end
			end
			m_hist = {m_hist[HIST_DEPTH-2:0], rx_bit};
			m_rx_word = {m_rx_word[`SERDES_RX_BITS-2:0], delayed}; // oldest ends in bit 3
			since_release++;
		end
	endtask

	task automatic check_value(string name, logic [7:0] got, logic [7:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_outputs();
		logic [`SERDES_TX_LANES-1:0] exp_tx;
		logic exp_valid;
		for (int i = 0; i < `SERDES_TX_LANES; i++) begin
			// bit 7 first down to bit 0 then idle low
			exp_tx[i] = (m_left[i] != 4'd0) &&
				(((m_word[i] >> (m_left[i] - 4'd1)) & 8'h01) != 8'h00);
		end
		exp_valid = (since_release > 0) && (since_release % `SERDES_RX_BITS == 0);
		check_value("locked", 8'(locked), 8'(exp_locked()));
		check_value("load0", 8'(load0), 8'(exp_load0()));
		check_value("load1", 8'(load1), 8'(exp_load1()));
		check_value("tx_bits", 8'(tx_bits), 8'(exp_tx));
		check_value("tap", 8'(tap), 8'(m_tap));
		check_value("rx_valid", 8'(rx_valid), 8'(exp_valid));
		check_value("rx_word", 8'(rx_word), 8'(m_rx_word));
	endtask

	task automatic drive_random(int cyc);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic up_bias;
		r0 = $urandom;
		r1 = $urandom;
		r2 = $urandom;
		up_bias = ((cyc / 96) % 2) == 0; // long runs one way so the tap wraps
		tx_words = {r0, r1[15:0]}; // new word on every lane each cycle
		if (r1[23:21] == 3'd0) begin
			word_clock1_sel = r1[17:16]; // phase moves now and then
		end
		rx_bit = r1[20];
		delay_ctrl.strobe = r2[0];
		delay_ctrl.inc_not_dec = up_bias ? (r2[3:2] != 2'b00) : (r2[3:2] == 2'b00);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		tx_words = '0;
		word_clock1_sel = '0;
		rx_bit = 1'b0;
		delay_ctrl = '0;
		for (int cyc = 0; cyc < RESET_CYCLES + TEST_CYCLES; cyc++) begin
			@(posedge clock);
			#1;
			step_model(); // inputs still hold what the edge sampled
			check_outputs();
			if (cyc + 1 >= RESET_CYCLES) begin
				rst_n = 1'b1;
				drive_random(cyc);
			end
		end
		assert (wraps_up > 0 && wraps_down > 0) else begin
			$display("CHECKS FAILED");
			$fatal(1, "tap never wrapped in both directions (up %0d, down %0d)",
				wraps_up, wraps_down);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
